/* logic/axil_slave.sv */
`timescale 1ns/1ps

module axil_slave import dna_mem_pkg::*; (
    input  logic      clk,
    input  logic      resetn,

    input  axi_addr_t i_axi_awaddr,
    input  logic      i_axi_awvalid,
    output logic      o_axi_awready,

    input  word_t     i_axi_wdata,
    input  logic      i_axi_wvalid,
    output logic      o_axi_wready,

    output logic      o_axi_bvalid,
    input  logic      i_axi_bready,

    input  axi_addr_t i_axi_araddr,
    input  logic      i_axi_arvalid,
    output logic      o_axi_arready,

    output word_t     o_axi_rdata,
    output logic      o_axi_rvalid,
    input  logic      i_axi_rready,

    mem_access_if.slave mem
);

    logic rd_wait; // bank data arrives next edge
    logic rd_busy;

    ////////////////////
    // Write channels
    ////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_axi_awready <= 1'b0;
            o_axi_wready  <= 1'b0;
            o_axi_bvalid  <= 1'b0;
            mem.wr_valid  <= 1'b0;
        end else begin
            o_axi_awready <= 1'b0;
            o_axi_wready  <= 1'b0;
            mem.wr_valid  <= 1'b0;
            if (o_axi_bvalid && i_axi_bready) begin
                o_axi_bvalid <= 1'b0;
            end
            if (o_axi_awready && i_axi_awvalid && i_axi_wvalid) begin
                mem.wr_valid <= 1'b1;
                o_axi_bvalid <= 1'b1; // held until bready
            end else if (i_axi_awvalid && i_axi_wvalid && !o_axi_bvalid) begin
                o_axi_awready <= 1'b1; // AW and W taken together
                o_axi_wready  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_axi_awready && i_axi_awvalid) begin
            mem.wr_addr <= i_axi_awaddr;
            mem.wr_data <= i_axi_wdata;
        end
    end

    ////////////////////
    // Read channels
    ////////////////////

    // One read in flight at a time
    assign rd_busy = o_axi_arready || mem.rd_valid || rd_wait || o_axi_rvalid;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_axi_arready <= 1'b0;
            mem.rd_valid  <= 1'b0;
            rd_wait       <= 1'b0;
            o_axi_rvalid  <= 1'b0;
        end else begin
            o_axi_arready <= 1'b0;
            mem.rd_valid  <= 1'b0;
            rd_wait       <= mem.rd_valid;
            if (o_axi_arready && i_axi_arvalid) begin
                mem.rd_valid <= 1'b1;
            end else if (i_axi_arvalid && !rd_busy) begin
                o_axi_arready <= 1'b1;
            end
            if (rd_wait) begin
                o_axi_rvalid <= 1'b1;
            end else if (o_axi_rvalid && i_axi_rready) begin
                o_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_axi_arready && i_axi_arvalid) begin
            mem.rd_addr <= i_axi_araddr;
        end
        if (rd_wait) begin
            o_axi_rdata <= mem.rd_data; // stays put while rvalid holds
        end
    end

endmodule

/* logic/dna_mem_pkg.sv */
package dna_mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] axi_addr_t;

    ////////////////////
    // Address map
    ////////////////////

    // Sequence write regions, 4 KB each
    localparam axi_addr_t SEQ_READ_BASE = 32'h0300_0000;
    localparam axi_addr_t SEQ_REF_BASE  = 32'h0300_1000;
    localparam int        SEQ_REGION_W  = 12; // log2 of region bytes

    // Matrix bank read regions
    localparam axi_addr_t MATRIX_BASE     = 32'h0301_0000; // bank 0
    localparam axi_addr_t MATRIX_STRIDE   = 32'h0001_0000;
    localparam int        MATRIX_STRIDE_W = 16; // log2 of MATRIX_STRIDE

    ////////////////////
    // Default sizes
    ////////////////////

    localparam int DEF_NUM_BANKS    = 4;
    localparam int DEF_SEQ_DEPTH    = 128; // words
    localparam int DEF_MATRIX_DEPTH = 128; // words

endpackage

/* logic/dna_mem_top.sv */
`timescale 1ns/1ps

module dna_mem_top import dna_mem_pkg::*; #(
    parameter int NUM_BANKS    = DEF_NUM_BANKS,
    parameter int SEQ_DEPTH    = DEF_SEQ_DEPTH,
    parameter int MATRIX_DEPTH = DEF_MATRIX_DEPTH,
    localparam int SEQ_IDX_W = (SEQ_DEPTH > 1) ? $clog2(SEQ_DEPTH) : 1,
    localparam int MAT_IDX_W = (MATRIX_DEPTH > 1) ? $clog2(MATRIX_DEPTH) : 1
) (
    input  logic                                clk,
    input  logic                                resetn,

    ////////////////////
    // AXI4-Lite
    input  axi_addr_t                           i_axi_awaddr,
    input  logic                                i_axi_awvalid,
    output logic                                o_axi_awready,
    input  word_t                               i_axi_wdata,
    input  logic                                i_axi_wvalid,
    output logic                                o_axi_wready,
    output logic                                o_axi_bvalid,
    input  logic                                i_axi_bready,
    input  axi_addr_t                           i_axi_araddr,
    input  logic                                i_axi_arvalid,
    output logic                                o_axi_arready,
    output word_t                               o_axi_rdata,
    output logic                                o_axi_rvalid,
    input  logic                                i_axi_rready,

    ////////////////////
    // Alignment core
    input  logic [SEQ_IDX_W-1:0]                i_read_idx,
    input  logic [SEQ_IDX_W-1:0]                i_ref_idx,
    output word_t                               o_read_word,
    output word_t                               o_ref_word,
    input  logic [NUM_BANKS-1:0]                i_matrix_we,
    input  logic [NUM_BANKS-1:0][MAT_IDX_W-1:0] i_matrix_idx,
    input  word_t [NUM_BANKS-1:0]               i_matrix_din
);

    mem_access_if mem_bus ();

    axil_slave u_axil_slave (
        .clk           (clk),
        .resetn        (resetn),
        .i_axi_awaddr  (i_axi_awaddr),
        .i_axi_awvalid (i_axi_awvalid),
        .o_axi_awready (o_axi_awready),
        .i_axi_wdata   (i_axi_wdata),
        .i_axi_wvalid  (i_axi_wvalid),
        .o_axi_wready  (o_axi_wready),
        .o_axi_bvalid  (o_axi_bvalid),
        .i_axi_bready  (i_axi_bready),
        .i_axi_araddr  (i_axi_araddr),
        .i_axi_arvalid (i_axi_arvalid),
        .o_axi_arready (o_axi_arready),
        .o_axi_rdata   (o_axi_rdata),
        .o_axi_rvalid  (o_axi_rvalid),
        .i_axi_rready  (i_axi_rready),
        .mem           (mem_bus.slave)
    );

    seq_buffers #(.SEQ_DEPTH(SEQ_DEPTH)) u_seq_buffers (
        .clk         (clk),
        .resetn      (resetn),
        .mem         (mem_bus.mem), // write half
        .i_read_idx  (i_read_idx),
        .i_ref_idx   (i_ref_idx),
        .o_read_word (o_read_word),
        .o_ref_word  (o_ref_word)
    );

    matrix_banks #(
        .NUM_BANKS    (NUM_BANKS),
        .MATRIX_DEPTH (MATRIX_DEPTH)
    ) u_matrix_banks (
        .clk          (clk),
        .resetn       (resetn),
        .mem          (mem_bus.mem), // read half
        .i_matrix_we  (i_matrix_we),
        .i_matrix_idx (i_matrix_idx),
        .i_matrix_din (i_matrix_din)
    );

endmodule

/* logic/dp_ram.sv */
`timescale 1ns/1ps

module dp_ram import dna_mem_pkg::*; #(
    parameter int DEPTH = DEF_SEQ_DEPTH,
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk,
    input  logic             i_we,
    input  logic [IDX_W-1:0] i_waddr,
    input  word_t            i_wdata,
    input  logic [IDX_W-1:0] i_raddr,
    output word_t            o_rdata
);

    word_t ram [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            ram[i_waddr] <= i_wdata;
        end
        o_rdata <= ram[i_raddr]; // old data on a same-address write
    end

endmodule

/* logic/matrix_banks.sv */
`timescale 1ns/1ps

module matrix_banks import dna_mem_pkg::*; #(
    parameter int NUM_BANKS    = DEF_NUM_BANKS,
    parameter int MATRIX_DEPTH = DEF_MATRIX_DEPTH,
    localparam int IDX_W = (MATRIX_DEPTH > 1) ? $clog2(MATRIX_DEPTH) : 1
) (
    input  logic                            clk,
    input  logic                            resetn,
    mem_access_if.mem                       mem,
    input  logic [NUM_BANKS-1:0]            i_matrix_we,
    input  logic [NUM_BANKS-1:0][IDX_W-1:0] i_matrix_idx,
    input  word_t [NUM_BANKS-1:0]           i_matrix_din
);

    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int OFS_W  = MATRIX_STRIDE_W - 2;

    axi_addr_t                          rel_addr;
    logic [ADDR_W-MATRIX_STRIDE_W-1:0]  bank_num;
    logic [OFS_W-1:0]                   word_ofs;
    logic [IDX_W-1:0]                   rd_idx;
    logic                               hit;
    logic [BANK_W-1:0]                  sel_q;
    logic                               hit_q;
    word_t [NUM_BANKS-1:0]              bank_dout;

    // Below MATRIX_BASE wraps to a large bank number and misses
    assign rel_addr = mem.rd_addr - MATRIX_BASE;
    assign bank_num = rel_addr[ADDR_W-1:MATRIX_STRIDE_W];
    assign word_ofs = rel_addr[MATRIX_STRIDE_W-1:2];
    assign rd_idx   = IDX_W'(word_ofs);
    assign hit      = (32'(bank_num) < NUM_BANKS) && (32'(word_ofs) < MATRIX_DEPTH);

    // Bank select lines up with the registered RAM output
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sel_q <= '0;
            hit_q <= 1'b0;
        end else if (mem.rd_valid) begin
            sel_q <= BANK_W'(bank_num);
            hit_q <= hit;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dp_ram #(.DEPTH(MATRIX_DEPTH)) u_bank (
            .clk     (clk),
            .i_we    (i_matrix_we[b]),
            .i_waddr (i_matrix_idx[b]),
            .i_wdata (i_matrix_din[b]),
            .i_raddr (rd_idx), // all banks share the AXI read index
            .o_rdata (bank_dout[b])
        );
    end

    assign mem.rd_data = hit_q ? bank_dout[sel_q] : '0; // zero on a miss

endmodule

/* logic/mem_access_if.sv */
`timescale 1ns/1ps

interface mem_access_if import dna_mem_pkg::*; ();

    // Write request, one-cycle pulse
    logic      wr_valid;
    axi_addr_t wr_addr;
    word_t     wr_data;

    // Read request, data follows one cycle after the pulse
    logic      rd_valid;
    axi_addr_t rd_addr;
    word_t     rd_data;

    modport slave (
        output wr_valid, wr_addr, wr_data,
        output rd_valid, rd_addr,
        input  rd_data
    );

    modport mem (
        input  wr_valid, wr_addr, wr_data,
        input  rd_valid, rd_addr,
        output rd_data
    );

endinterface

/* logic/seq_buffers.sv */
`timescale 1ns/1ps

module seq_buffers import dna_mem_pkg::*; #(
    parameter int SEQ_DEPTH = DEF_SEQ_DEPTH,
    localparam int IDX_W = (SEQ_DEPTH > 1) ? $clog2(SEQ_DEPTH) : 1
) (
    input  logic             clk,
    input  logic             resetn,
    mem_access_if.mem        mem,
    input  logic [IDX_W-1:0] i_read_idx,
    input  logic [IDX_W-1:0] i_ref_idx,
    output word_t            o_read_word,
    output word_t            o_ref_word
);

    localparam int OFS_W = SEQ_REGION_W - 2; // word offset within a region

    logic [OFS_W-1:0] word_ofs;
    logic [IDX_W-1:0] waddr;
    logic             in_depth;
    logic             hit_read;
    logic             hit_ref;
    logic             we_read;
    logic             we_ref;

    // Region decode on the upper address bits
    assign hit_read = mem.wr_addr[ADDR_W-1:SEQ_REGION_W] == SEQ_READ_BASE[ADDR_W-1:SEQ_REGION_W];
    assign hit_ref  = mem.wr_addr[ADDR_W-1:SEQ_REGION_W] == SEQ_REF_BASE[ADDR_W-1:SEQ_REGION_W];

    assign word_ofs = mem.wr_addr[SEQ_REGION_W-1:2];
    assign in_depth = 32'(word_ofs) < SEQ_DEPTH; // beyond buffer end is dropped
    assign waddr    = IDX_W'(word_ofs);

    // No RAM writes while held in reset
    assign we_read = resetn && mem.wr_valid && hit_read && in_depth;
    assign we_ref  = resetn && mem.wr_valid && hit_ref && in_depth;

    dp_ram #(.DEPTH(SEQ_DEPTH)) u_read_buf (
        .clk     (clk),
        .i_we    (we_read),
        .i_waddr (waddr),
        .i_wdata (mem.wr_data),
        .i_raddr (i_read_idx),
        .o_rdata (o_read_word)
    );

    dp_ram #(.DEPTH(SEQ_DEPTH)) u_ref_buf (
        .clk     (clk),
        .i_we    (we_ref),
        .i_waddr (waddr),
        .i_wdata (mem.wr_data),
        .i_raddr (i_ref_idx),
        .o_rdata (o_ref_word)
    );

endmodule

/* project.f */
logic/dna_mem_pkg.sv
logic/mem_access_if.sv
logic/dp_ram.sv
logic/axil_slave.sv
logic/seq_buffers.sv
logic/matrix_banks.sv
logic/dna_mem_top.sv
tests/tb_clock.sv
tests/dna_mem_properties.sv
tests/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_top \
    -Mdir "$BUILD_DIR" -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

/* tests/dna_mem_properties.sv */
`timescale 1ns/1ps

module dna_mem_properties import dna_mem_pkg::*; (
    input logic  clk,
    input logic  resetn,
    input logic  o_axi_awready,
    input logic  o_axi_wready,
    input logic  o_axi_bvalid,
    input logic  i_axi_bready,
    input logic  o_axi_rvalid,
    input word_t o_axi_rdata,
    input logic  i_axi_rready
);

    int assert_errors = 0; // read by the testbench at the end

    ////////////////////
    // Write response
    ////////////////////

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_axi_bvalid && !i_axi_bready |=> o_axi_bvalid)
    else begin
        $error("bvalid dropped before bready");
        assert_errors++;
    end

    a_aw_w_ready: assert property (@(posedge clk) disable iff (!resetn)
        o_axi_awready == o_axi_wready)
    else begin
        $error("awready and wready differ");
        assert_errors++;
    end

    ////////////////////
    // Read data
    ////////////////////

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_axi_rvalid && !i_axi_rready |=> o_axi_rvalid && $stable(o_axi_rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        assert_errors++;
    end

endmodule

bind axil_slave dna_mem_properties u_props (.*);

/* tests/stimulus_input.txt */
# op  addr_or_index  data  expected (hex); seq_rd/ref_rd take a word index
# mat_wr index field is bank * 0x100 + word index; unused fields are 0
axi_wr 03000000 a5a50001 00000000
axi_wr 03000010 a5a50004 00000000
axi_wr 030001fc a5a5007f 00000000
seq_rd 00000000 00000000 a5a50001
seq_rd 00000004 00000000 a5a50004
seq_rd 0000007f 00000000 a5a5007f
axi_wr 03001010 c3c30004 00000000
axi_wr 03001000 c3c30000 00000000
ref_rd 00000004 00000000 c3c30004
ref_rd 00000000 00000000 c3c30000
seq_rd 00000004 00000000 a5a50004
mat_wr 00000005 11110005 00000000
mat_wr 00000100 22220000 00000000
mat_wr 0000027f 3333007f 00000000
mat_wr 0000030a 4444000a 00000000
axi_rd 03010014 00000000 11110005
axi_rd 03020000 00000000 22220000
axi_rd 030301fc 00000000 3333007f
axi_rd 03040028 00000000 4444000a
axi_rd 03050000 00000000 00000000
axi_rd 02ff0000 00000000 00000000
axi_rd 03010200 00000000 00000000
axi_wr 03002010 deadbeef 00000000
seq_rd 00000004 00000000 a5a50004
ref_rd 00000004 00000000 c3c30004
axi_wr 03000200 0badf00d 00000000
seq_rd 00000000 00000000 a5a50001

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 20 // 40 ns period
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) o_clk = ~o_clk;
        end
    end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top import dna_mem_pkg::*; ();

    localparam int SEQ_IDX_W       = $clog2(DEF_SEQ_DEPTH);
    localparam int MAT_IDX_W       = $clog2(DEF_MATRIX_DEPTH);
    localparam int BANK_W          = $clog2(DEF_NUM_BANKS);
    localparam int CYCLES_PER_LINE = 40;

    logic                                    clk;
    logic                                    resetn;
    axi_addr_t                               i_axi_awaddr;
    logic                                    i_axi_awvalid;
    logic                                    o_axi_awready;
    word_t                                   i_axi_wdata;
    logic                                    i_axi_wvalid;
    logic                                    o_axi_wready;
    logic                                    o_axi_bvalid;
    logic                                    i_axi_bready;
    axi_addr_t                               i_axi_araddr;
    logic                                    i_axi_arvalid;
    logic                                    o_axi_arready;
    word_t                                   o_axi_rdata;
    logic                                    o_axi_rvalid;
    logic                                    i_axi_rready;
    logic [SEQ_IDX_W-1:0]                    i_read_idx;
    logic [SEQ_IDX_W-1:0]                    i_ref_idx;
    word_t                                   o_read_word;
    word_t                                   o_ref_word;
    logic [DEF_NUM_BANKS-1:0]                i_matrix_we;
    logic [DEF_NUM_BANKS-1:0][MAT_IDX_W-1:0] i_matrix_idx;
    word_t [DEF_NUM_BANKS-1:0]               i_matrix_din;

    // Test table from the data file
    string     op_q[$];
    axi_addr_t addr_q[$];
    word_t     data_q[$];
    word_t     exp_q[$];

    int   seed        = 32'h0bf1_b897;
    int   line_count  = 0;
    int   cycle_limit = 0;
    int   cycle_count = 0;
    int   errors      = 0;
    int   checks      = 0;
    int   n_writes    = 0;
    int   n_reads     = 0;
    int   b_rises     = 0;
    int   r_rises     = 0;
    logic bvalid_q    = 1'b0;
    logic rvalid_q    = 1'b0;

    tb_clock u_clock (.o_clk(clk));

    dna_mem_top DUT (
        .clk           (clk),
        .resetn        (resetn),
        .i_axi_awaddr  (i_axi_awaddr),
        .i_axi_awvalid (i_axi_awvalid),
        .o_axi_awready (o_axi_awready),
        .i_axi_wdata   (i_axi_wdata),
        .i_axi_wvalid  (i_axi_wvalid),
        .o_axi_wready  (o_axi_wready),
        .o_axi_bvalid  (o_axi_bvalid),
        .i_axi_bready  (i_axi_bready),
        .i_axi_araddr  (i_axi_araddr),
        .i_axi_arvalid (i_axi_arvalid),
        .o_axi_arready (o_axi_arready),
        .o_axi_rdata   (o_axi_rdata),
        .o_axi_rvalid  (o_axi_rvalid),
        .i_axi_rready  (i_axi_rready),
        .i_read_idx    (i_read_idx),
        .i_ref_idx     (i_ref_idx),
        .o_read_word   (o_read_word),
        .o_ref_word    (o_ref_word),
        .i_matrix_we   (i_matrix_we),
        .i_matrix_idx  (i_matrix_idx),
        .i_matrix_din  (i_matrix_din)
    );

    ////////////////////
    // Monitors
    ////////////////////

    // Each rising valid is one response
    always @(posedge clk) begin
        bvalid_q <= o_axi_bvalid;
        rvalid_q <= o_axi_rvalid;
        if (o_axi_bvalid && !bvalid_q) begin
            b_rises <= b_rises + 1;
        end
        if (o_axi_rvalid && !rvalid_q) begin
            r_rises <= r_rises + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////
    // Tasks
    ////////////////////

    task automatic check(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    function automatic int ready_delay();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    // Nonzero, tied to bank and index
    function automatic word_t fill_word(input int bank, input int idx);
        return {8'hf1, 8'(bank), 16'(idx)};
    endfunction

    task automatic load_stimulus();
        int        fd;
        int        n;
        string     line;
        string     op;
        axi_addr_t a;
        word_t     d;
        word_t     e;
        fd = $fopen("tests/stimulus_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/stimulus_input.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                line_count++;
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h", op, a, d, e);
                    if (n == 4) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        if (op_q.size() == 0) begin
            $display("No test operations found in the stimulus file");
            errors++;
        end
    endtask

    // Every bank word written once, all banks in parallel
    task automatic fill_banks();
        @(posedge clk);
        for (int k = 0; k < DEF_MATRIX_DEPTH; k++) begin
            for (int b = 0; b < DEF_NUM_BANKS; b++) begin
                i_matrix_idx[b] <= MAT_IDX_W'(k);
                i_matrix_din[b] <= fill_word(b, k);
            end
            i_matrix_we <= '1;
            @(posedge clk);
        end
        i_matrix_we <= '0;
    endtask

    task automatic axi_write(input axi_addr_t addr, input word_t data, input string name);
        int delay;
        delay = ready_delay();
        @(posedge clk);
        i_axi_awaddr  <= addr;
        i_axi_awvalid <= 1'b1;
        i_axi_wdata   <= data;
        i_axi_wvalid  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!o_axi_awready);
        i_axi_awvalid <= 1'b0;
        i_axi_wvalid  <= 1'b0;
        while (!o_axi_bvalid) begin
            @(posedge clk);
        end
        repeat (delay) @(posedge clk);
        i_axi_bready <= 1'b1;
        @(posedge clk); // B handshake
        i_axi_bready <= 1'b0;
        @(posedge clk);
        check({name, "_bvalid_after_bready"}, '0, word_t'(o_axi_bvalid));
        n_writes++;
    endtask

    task automatic axi_read(input axi_addr_t addr, output word_t data);
        int delay;
        delay = ready_delay();
        @(posedge clk);
        i_axi_araddr  <= addr;
        i_axi_arvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!o_axi_arready);
        i_axi_arvalid <= 1'b0;
        while (!o_axi_rvalid) begin
            @(posedge clk);
        end
        repeat (delay) @(posedge clk);
        i_axi_rready <= 1'b1;
        @(posedge clk);
        data = o_axi_rdata; // R handshake
        i_axi_rready <= 1'b0;
        n_reads++;
    endtask

    task automatic seq_read(input logic ref_side, input axi_addr_t idx, output word_t data);
        @(posedge clk);
        if (ref_side) begin
            i_ref_idx <= idx[SEQ_IDX_W-1:0];
        end else begin
            i_read_idx <= idx[SEQ_IDX_W-1:0];
        end
        @(posedge clk); // RAM takes the index
        @(posedge clk);
        data = ref_side ? o_ref_word : o_read_word;
    endtask

    // Field holds bank * 0x100 + word index
    task automatic matrix_write(input axi_addr_t field, input word_t data);
        logic [BANK_W-1:0] bank;
        bank = field[BANK_W+7:8];
        @(posedge clk);
        i_matrix_we[bank]  <= 1'b1;
        i_matrix_idx[bank] <= field[MAT_IDX_W-1:0];
        i_matrix_din[bank] <= data;
        @(posedge clk);
        i_matrix_we <= '0;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        word_t actual;
        string name;
        int    err_before;
        resetn        = 1'b0;
        i_axi_awaddr  = '0;
        i_axi_awvalid = 1'b0;
        i_axi_wdata   = '0;
        i_axi_wvalid  = 1'b0;
        i_axi_bready  = 1'b0;
        i_axi_araddr  = '0;
        i_axi_arvalid = 1'b0;
        i_axi_rready  = 1'b0;
        i_read_idx    = '0;
        i_ref_idx     = '0;
        i_matrix_we   = '0;
        i_matrix_idx  = '0;
        i_matrix_din  = '0;
        load_stimulus();
        cycle_limit = CYCLES_PER_LINE * line_count + DEF_MATRIX_DEPTH;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        fill_banks(); // a miss that aliases a bank word would read nonzero
        for (int i = 0; i < op_q.size(); i++) begin
            name       = $sformatf("%0d_%s", i + 1, op_q[i]);
            err_before = errors;
            case (op_q[i])
                "axi_wr": axi_write(addr_q[i], data_q[i], name);
                "axi_rd": begin
                    axi_read(addr_q[i], actual);
                    check(name, exp_q[i], actual);
                end
                "seq_rd": begin
                    seq_read(1'b0, addr_q[i], actual);
                    check(name, exp_q[i], actual);
                end
                "ref_rd": begin
                    seq_read(1'b1, addr_q[i], actual);
                    check(name, exp_q[i], actual);
                end
                "mat_wr": matrix_write(addr_q[i], data_q[i]);
                default: begin
                    $display("Unknown operation %s in test %0d", op_q[i], i + 1);
                    errors++;
                end
            endcase
            if (errors == err_before) begin
                $display("%s: ok", name);
            end else begin
                $display("%s: error", name);
            end
        end
        repeat (2) @(posedge clk);
        check("write_responses", word_t'(n_writes), word_t'(b_rises));
        check("read_responses", word_t'(n_reads), word_t'(r_rises));
        check("assertion_failures", '0, word_t'(DUT.u_axil_slave.u_props.assert_errors));
        $display("%0d tests, %0d checks, %0d errors", op_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
